// File: build.f
radar_pkg.sv
param_sync.sv
pulse_timers.sv
pulse_sequencer.sv
radar_pulse_controller.sv
radar_pulse_controller_properties.sv
radar_pulse_controller_tb.sv

// File: param_sync.sv
`timescale 1ns/1ps

module param_sync #(
  parameter logic [radar_pkg::word_w-1:0] reset_value = '0
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic [radar_pkg::word_w-1:0]  din,
  output logic [radar_pkg::word_w-1:0]  dout
);

  import radar_pkg::*;

  // first two capture stages
  logic [word_w-1:0] din_r;
  logic [word_w-1:0] din_rr;
  // held copy, follows din_rr only on a change
  logic [word_w-1:0] din_rrr;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      din_r   <= reset_value;
      din_rr  <= reset_value;
      din_rrr <= reset_value;
    end else begin
      din_r  <= din;
      din_rr <= din_r;
      // change detect on the second stage
      if (din_rrr != din_rr) begin
        din_rrr <= din_rr;
      end
    end
  end

  // new word shows up three edges after din changes
  assign dout = din_rrr;

endmodule

// File: pulse_sequencer.sv
`timescale 1ns/1ps

module pulse_sequencer (
  input  logic                   aclk,
  input  logic                   aresetn,
  // dac side status
  input  logic                   chirp_ready,
  input  logic                   chirp_active,
  input  logic                   chirp_done,
  // flags from the phase timers
  input  logic                   prf_done,
  input  logic                   collect_done,
  input  logic                   process_done,
  input  logic                   overhead_done,
  output radar_pkg::gen_state_t  state,
  // chirp and adc control
  output logic                   chirp_init,
  output logic                   chirp_enable,
  output logic                   adc_enable
);

  import radar_pkg::*;

  gen_state_t next_state;

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  always_comb begin
    next_state = state;
    case (state)
      // one cycle here when the dac is ready
      idle: begin
        if (chirp_ready) begin
          next_state = active;
        end
      end
      // pulse repetition wait
      active: begin
        if (chirp_ready && prf_done) begin
          next_state = chirp;
        end
      end
      // chirp running, adc already sampling
      chirp: begin
        if (chirp_done) begin
          next_state = collect;
        end
      end
      // remaining adc window
      collect: begin
        if (collect_done) begin
          next_state = process;
        end
      end
      process: begin
        if (process_done) begin
          next_state = overhead;
        end
      end
      // clean up, then start over
      overhead: begin
        if (overhead_done) begin
          next_state = idle;
        end
      end
      // unused encodings
      default: begin
        next_state = idle;
      end
    endcase
  end

  ////////////////////////////////////////
  // state register
  ////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  ////////////////////////////////////////
  // control outputs
  ////////////////////////////////////////

  // all three lag the state by one cycle
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      chirp_enable <= 1'b0;
      chirp_init   <= 1'b0;
      adc_enable   <= 1'b0;
    end else begin
      // level for the whole chirp state
      chirp_enable <= (state == chirp);
      // one shot, chirp_enable is still low only in the first chirp cycle
      chirp_init <= (state == chirp) && !chirp_active && !chirp_enable;
      // sampling covers chirp and collect
      adc_enable <= (state == chirp) || (state == collect);
    end
  end

endmodule

// File: pulse_timers.sv
`timescale 1ns/1ps

module pulse_timers (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic [radar_pkg::word_w-1:0]  prf_int,
  input  logic [radar_pkg::word_w-1:0]  prf_frac,
  input  logic [radar_pkg::word_w-1:0]  adc_count,
  input  radar_pkg::gen_state_t         state,
  output logic                          prf_done,
  output logic                          collect_done,
  output logic                          process_done,
  output logic                          overhead_done
);

  import radar_pkg::*;

  ////////////////////////////////////////
  // period limits
  ////////////////////////////////////////

  // integer word on top, fraction word below
  logic [prf_count_w-1:0] prf_count_max;
  // collection window length
  logic [word_w-1:0]      adc_count_max;

  // one extra register stage after the capture
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      prf_count_max <= {prf_int_init, prf_frac_init};
      adc_count_max <= adc_sample_count_init;
    end else begin
      prf_count_max <= {prf_int, prf_frac};
      adc_count_max <= adc_count;
    end
  end

  ////////////////////////////////////////
  // phase countdowns
  ////////////////////////////////////////

  logic [prf_count_w-1:0] prf_count;
  logic [word_w-1:0]      collect_count;
  logic [3:0]             process_count;
  logic [3:0]             overhead_count;

  // pulse repetition wait, runs in active
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      prf_count <= '0;
    end else if (state == idle) begin
      prf_count <= prf_count_max;
    end else if (state == active && prf_count != '0) begin
      prf_count <= prf_count - 1'b1;
    end
  end

  // adc collection window, runs in collect
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      collect_count <= '0;
    end else if (state == idle) begin
      collect_count <= adc_count_max;
    end else if (state == collect && collect_count != '0) begin
      collect_count <= collect_count - 1'b1;
    end
  end

  // fixed processing phase
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      process_count <= '0;
    end else if (state == idle) begin
      process_count <= process_cycles;
    end else if (state == process && process_count != '0) begin
      process_count <= process_count - 1'b1;
    end
  end

  // fixed overhead phase before idle
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      overhead_count <= '0;
    end else if (state == idle) begin
      overhead_count <= overhead_cycles;
    end else if (state == overhead && overhead_count != '0) begin
      overhead_count <= overhead_count - 1'b1;
    end
  end

  ////////////////////////////////////////
  // finish flags
  ////////////////////////////////////////

  // active holds P+1 cycles
  assign prf_done = (prf_count == '0);

  // a zero window still ends after one cycle
  assign collect_done = (collect_count <= 32'd1);

  assign process_done = (process_count <= 4'd1);

  assign overhead_done = (overhead_count <= 4'd1);

endmodule

// File: radar_pkg.sv
package radar_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // one register-map word
  localparam int word_w = 32;
  // four chirp words packed together
  localparam int param_bus_w = 4 * word_w;
  // upper word is the integer part, lower word the fraction
  localparam int prf_count_w = 2 * word_w;

  ////////////////////////////////////////
  // register-map reset values
  ////////////////////////////////////////

  // chirp generator words
  // 3584 samples per chirp
  localparam logic [word_w-1:0] chirp_count_max_init = 32'h0000_0dff;
  localparam logic [word_w-1:0] chirp_tuning_coef_init = 32'h0000_0001;
  // sets the lowest chirp frequency
  localparam logic [word_w-1:0] chirp_freq_offset_init = 32'h0000_0b00;
  localparam logic [word_w-1:0] chirp_ctrl_word_init = 32'h0000_0020;

  // pulse repetition period halves
  localparam logic [word_w-1:0] prf_int_init = 32'h0000_0000;
  localparam logic [word_w-1:0] prf_frac_init = 32'h1d4c_0000;

  // adc collection window in cycles
  localparam logic [word_w-1:0] adc_sample_count_init = 32'h0000_01fe;

  ////////////////////////////////////////
  // fixed phase lengths
  ////////////////////////////////////////

  localparam logic [3:0] process_cycles = 4'd2;
  localparam logic [3:0] overhead_cycles = 4'd2;

  // sequencer states, encodings 5 and 6 unused
  typedef enum logic [2:0] {
    idle     = 3'b000,
    active   = 3'b001,
    chirp    = 3'b010,
    collect  = 3'b011,
    process  = 3'b100,
    overhead = 3'b111
  } gen_state_t;

endpackage

// File: radar_pulse_controller.sv
`timescale 1ns/1ps

module radar_pulse_controller (
  input  logic                               aclk,
  input  logic                               aresetn,
  // dac handshake levels and pulses
  input  logic                               chirp_ready,
  input  logic                               chirp_active,
  input  logic                               chirp_done,
  // register map
  input  logic [radar_pkg::word_w-1:0]       chirp_time_int,
  input  logic [radar_pkg::word_w-1:0]       chirp_time_frac,
  input  logic [radar_pkg::word_w-1:0]       adc_sample_time,
  input  logic [radar_pkg::param_bus_w-1:0]  chirp_parameters_in,
  output logic [radar_pkg::param_bus_w-1:0]  chirp_parameters_out,
  // chirp and adc control
  output logic                               chirp_init,
  output logic                               chirp_enable,
  output logic                               adc_enable
);

  import radar_pkg::*;

  // captured register-map words
  logic [word_w-1:0] ch_counter_max;
  logic [word_w-1:0] ch_tuning_coef;
  logic [word_w-1:0] ch_freq_offset;
  logic [word_w-1:0] ch_ctrl_word;
  logic [word_w-1:0] prf_int;
  logic [word_w-1:0] prf_frac;
  logic [word_w-1:0] adc_count;

  // sequencer and timer wiring
  gen_state_t gen_state;
  logic       prf_done;
  logic       collect_done;
  logic       process_done;
  logic       overhead_done;

  ////////////////////////////////////////
  // chirp parameter capture
  ////////////////////////////////////////

  param_sync #(.reset_value(chirp_count_max_init)) counter_max_sync_i (
    .aclk(aclk), .aresetn(aresetn),
    .din(chirp_parameters_in[word_w-1:0]), .dout(ch_counter_max)
  );

  param_sync #(.reset_value(chirp_tuning_coef_init)) tuning_coef_sync_i (
    .aclk(aclk), .aresetn(aresetn),
    .din(chirp_parameters_in[2*word_w-1:word_w]), .dout(ch_tuning_coef)
  );

  param_sync #(.reset_value(chirp_freq_offset_init)) freq_offset_sync_i (
    .aclk(aclk), .aresetn(aresetn),
    .din(chirp_parameters_in[3*word_w-1:2*word_w]), .dout(ch_freq_offset)
  );

  param_sync #(.reset_value(chirp_ctrl_word_init)) ctrl_word_sync_i (
    .aclk(aclk), .aresetn(aresetn),
    .din(chirp_parameters_in[4*word_w-1:3*word_w]), .dout(ch_ctrl_word)
  );

  // ctrl word on top, counter max at the bottom
  assign chirp_parameters_out = {ch_ctrl_word, ch_freq_offset, ch_tuning_coef, ch_counter_max};

  ////////////////////////////////////////
  // timing word capture
  ////////////////////////////////////////

  param_sync #(.reset_value(prf_int_init)) prf_int_sync_i (
    .aclk(aclk), .aresetn(aresetn), .din(chirp_time_int), .dout(prf_int)
  );

  param_sync #(.reset_value(prf_frac_init)) prf_frac_sync_i (
    .aclk(aclk), .aresetn(aresetn), .din(chirp_time_frac), .dout(prf_frac)
  );

  param_sync #(.reset_value(adc_sample_count_init)) adc_count_sync_i (
    .aclk(aclk), .aresetn(aresetn), .din(adc_sample_time), .dout(adc_count)
  );

  ////////////////////////////////////////
  // timers and sequencer
  ////////////////////////////////////////

  pulse_timers pulse_timers_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .prf_int       (prf_int),
    .prf_frac      (prf_frac),
    .adc_count     (adc_count),
    .state         (gen_state),
    .prf_done      (prf_done),
    .collect_done  (collect_done),
    .process_done  (process_done),
    .overhead_done (overhead_done)
  );

  pulse_sequencer pulse_sequencer_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .chirp_ready   (chirp_ready),
    .chirp_active  (chirp_active),
    .chirp_done    (chirp_done),
    .prf_done      (prf_done),
    .collect_done  (collect_done),
    .process_done  (process_done),
    .overhead_done (overhead_done),
    .state         (gen_state),
    .chirp_init    (chirp_init),
    .chirp_enable  (chirp_enable),
    .adc_enable    (adc_enable)
  );

endmodule

// File: radar_pulse_controller_properties.sv
`timescale 1ns/1ps

module radar_pulse_controller_properties (
  input logic aclk,
  input logic aresetn,
  input logic chirp_init,
  input logic chirp_enable,
  input logic adc_enable
);

  // running count of failed assertions
  int assert_errors = 0;

  ////////////////////////////////////////
  // chirp control rules
  ////////////////////////////////////////

  // chirp_init is a one-cycle pulse
  single_init_a: assert property (
    @(posedge aclk) disable iff (!aresetn) chirp_init |=> !chirp_init
  ) else begin
    assert_errors++;
    $error("chirp_init high on two consecutive cycles");
  end

  // one shot lines up with the rise of chirp_enable, which was still low before
  init_before_enable_a: assert property (
    @(posedge aclk) disable iff (!aresetn) chirp_init |-> $rose(chirp_enable)
  ) else begin
    assert_errors++;
    $error("chirp_init without chirp_enable rising from low");
  end

  // all outputs quiet straight out of reset
  reset_quiet_a: assert property (
    @(posedge aclk) !aresetn |=> (!chirp_init && !chirp_enable && !adc_enable)
  ) else begin
    assert_errors++;
    $error("control output high in the cycle after reset");
  end

endmodule

bind pulse_sequencer radar_pulse_controller_properties sequencer_props_i (
  .aclk         (aclk),
  .aresetn      (aresetn),
  .chirp_init   (chirp_init),
  .chirp_enable (chirp_enable),
  .adc_enable   (adc_enable)
);

// File: radar_pulse_controller_tb.sv
`timescale 1ns/1ps

module radar_pulse_controller_tb;

  import radar_pkg::*;

  ////////////////////////////////////////
  // dut signals
  ////////////////////////////////////////

  logic                   aclk;
  logic                   aresetn;
  logic                   chirp_ready;
  logic                   chirp_active;
  logic                   chirp_done;
  logic [word_w-1:0]      chirp_time_int;
  logic [word_w-1:0]      chirp_time_frac;
  logic [word_w-1:0]      adc_sample_time;
  logic [param_bus_w-1:0] chirp_parameters_in;
  logic [param_bus_w-1:0] chirp_parameters_out;
  logic                   chirp_init;
  logic                   chirp_enable;
  logic                   adc_enable;

  // rising edges since time zero
  int cyc = 0;
  int checks = 0;
  int errors = 0;
  int timeouts = 0;
  int init_count = 0;
  // window length for the chirp now running
  int n_cur = 0;
  int exp_spacing = 0;
  int exp_tail = 0;
  int exp_startup = 0;
  // cycle index of the first cycle after the reference edge
  int ready_cyc = 0;
  int done_cyc = 0;
  // chirp responder countdown
  int resp_wait = 0;
  bit adc_open = 1'b0;
  int adc_high = 0;

  radar_pulse_controller radar_pulse_controller_i (
    .aclk                 (aclk),
    .aresetn              (aresetn),
    .chirp_ready          (chirp_ready),
    .chirp_active         (chirp_active),
    .chirp_done           (chirp_done),
    .chirp_time_int       (chirp_time_int),
    .chirp_time_frac      (chirp_time_frac),
    .adc_sample_time      (adc_sample_time),
    .chirp_parameters_in  (chirp_parameters_in),
    .chirp_parameters_out (chirp_parameters_out),
    .chirp_init           (chirp_init),
    .chirp_enable         (chirp_enable),
    .adc_enable           (adc_enable)
  );

  // 4 ns period
  always #2 aclk = ~aclk;

  always @(posedge aclk) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////
  // timing model
  ////////////////////////////////////////

  function automatic void ref_timing(input int n, input int p, output int spacing,
                                     output int tail, output int startup);
    int n_eff;
    // empty window still takes one cycle
    n_eff = (n == 0) ? 1 : n;
    // collect, process, overhead, idle, active, then first chirp cycle
    spacing = n_eff + 2 + 2 + 1 + (p + 1) + 1;
    tail = n_eff;
    // from idle straight into active, then first chirp cycle
    startup = (p + 1) + 1;
  endfunction

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s, got 'h%0h expected 'h%0h", $time, what, got, exp);
    end
  endtask

  // wait on rising edges so init_count is settled
  task automatic wait_for_inits(input int target, input int limit, input string what);
    int n;
    n = 0;
    while (init_count < target && n < limit) begin
      @(posedge aclk);
      n++;
    end
    if (init_count < target) begin
      timeouts++;
      $display("timeout: %s did not arrive within %0d cycles", what, limit);
    end
  endtask

  task automatic end_run();
    int sva_errors;
    sva_errors = radar_pulse_controller_i.pulse_sequencer_i.sequencer_props_i.assert_errors;
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             checks, errors, sva_errors, timeouts);
    if (errors == 0 && timeouts == 0 && sva_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  ////////////////////////////////////////
  // chirp responder
  ////////////////////////////////////////

  // dac model, active after chirp_init, done after a random delay
  always @(negedge aclk) begin : responder
    int p_new;
    int n_new;
    int unused;
    if (aresetn) begin
      if (resp_wait > 0) begin
        resp_wait = resp_wait - 1;
        if (resp_wait == 0) begin
          chirp_done = 1'b1;
          // new period and window, picked up at the next idle
          p_new = $urandom % 16;
          n_new = (init_count % 4 == 2) ? 0 : $urandom % 13;
          chirp_time_frac = p_new;
          adc_sample_time = n_new;
          // this window ran already, period is the new one
          ref_timing(n_cur, p_new, exp_spacing, exp_tail, unused);
          n_cur = n_new;
          done_cyc = cyc + 1;
          adc_high = 0;
          adc_open = 1'b1;
        end
      end else if (chirp_done) begin
        chirp_done = 1'b0;
        chirp_active = 1'b0;
      end else if (chirp_init) begin
        chirp_active = 1'b1;
        resp_wait = 1 + $urandom % 6;
      end
    end
  end

  ////////////////////////////////////////
  // monitor
  ////////////////////////////////////////

  always @(negedge aclk) begin : monitor
    int k;
    if (aresetn) begin
      k = cyc - done_cyc;
      // cycle 0 still carries the chirp state
      if (adc_open && k >= 1) begin
        // a window running too long closes one cycle past the tail
        if (adc_enable && adc_high <= exp_tail) begin
          adc_high++;
        end else begin
          check_value("adc_enable tail after chirp_done", adc_high, exp_tail);
          adc_open = 1'b0;
        end
      end
      if (chirp_init) begin
        if (init_count == 0) begin
          check_value("first chirp_init after chirp_ready", cyc - ready_cyc, exp_startup);
        end else begin
          check_value("chirp_init spacing from chirp_done", k, exp_spacing);
        end
        init_count++;
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    int r;
    int start_p;
    logic [param_bus_w-1:0] old_params;
    logic [param_bus_w-1:0] new_params;
    void'($urandom(32'h5c40_1cbc));
    aclk = 1'b0;
    aresetn = 1'b0;
    chirp_ready = 1'b0;
    chirp_active = 1'b0;
    chirp_done = 1'b0;
    // short period and window from the start
    start_p = $urandom % 16;
    n_cur = $urandom % 13;
    chirp_time_int = '0;
    chirp_time_frac = start_p;
    adc_sample_time = n_cur;
    chirp_parameters_in = {32'h20, 32'hb00, 32'h1, 32'hdff};
    repeat (3) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);
    check_value("chirp_init after reset", chirp_init, 0);
    check_value("chirp_enable after reset", chirp_enable, 0);
    check_value("adc_enable after reset", adc_enable, 0);
    check_value("chirp_parameters_out after reset", chirp_parameters_out,
                {32'h20, 32'hb00, 32'h1, 32'hdff});
    // capture latency, old word for two cycles, new one on the third
    old_params = {32'h20, 32'hb00, 32'h1, 32'hdff};
    for (r = 0; r < 6; r++) begin
      new_params = {$urandom, $urandom, $urandom, $urandom};
      chirp_parameters_in = new_params;
      repeat (2) @(negedge aclk);
      check_value("chirp_parameters_out two cycles after a write", chirp_parameters_out,
                  old_params);
      @(negedge aclk);
      check_value("chirp_parameters_out three cycles after a write", chirp_parameters_out,
                  new_params);
      old_params = new_params;
    end
    // dac not ready, sequencer must sit in idle
    repeat (30) @(negedge aclk);
    @(posedge aclk);
    check_value("chirp_init count while chirp_ready low", init_count, 0);
    ref_timing(n_cur, start_p, exp_spacing, exp_tail, exp_startup);
    @(negedge aclk);
    chirp_ready = 1'b1;
    ready_cyc = cyc + 1;
    wait_for_inits(1, 60, "first chirp_init");
    // sixteen more pulses with fresh period and window each
    for (r = 2; r <= 17 && timeouts == 0; r++) begin
      wait_for_inits(r, 120, "next chirp_init");
    end
    end_run();
  end

endmodule
